// ==== design/l2_cache_pkg.sv ====
`include "l2_cache_settings.svh"

package l2_cache_pkg;

    // byte address as seen by the cache
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] word;
        logic [1:0]              byte_off;
    } l2_addr_fields_s;

    typedef union packed {
        logic [`L2_ADDR_W-1:0] raw;  // bus view
        l2_addr_fields_s       f;    // cache view
    } l2_addr_u;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic, requester side
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        l2_addr_u              adr;
        logic [`L2_DATA_W-1:0] dat;
    } cpu_req_s;

    typedef struct packed {
        logic                  ack;
        logic [`L2_DATA_W-1:0] dat;
    } cpu_rsp_s;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic, memory side
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`L2_ADDR_W-1:0] adr;
        logic [`L2_DATA_W-1:0] dat;
    } mem_req_s;

    typedef struct packed {
        logic                  ack;
        logic [`L2_DATA_W-1:0] dat;
    } mem_rsp_s;

endpackage

// ==== design/l2_cache_settings.svh ====
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// bus widths
`define L2_ADDR_W   32
`define L2_DATA_W   32

// geometry, 4 words per line, 16 sets, 2 ways
`define L2_OFFSET_W 2
`define L2_INDEX_W  4
`define L2_WAYS     2
`define L2_WAY_W    1

// addr minus index, offset and byte bits
`define L2_TAG_W    24

`endif

// ==== design/l2_cache_top.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  l2_cache_pkg::cpu_req_s cpu_req_i,
    output l2_cache_pkg::cpu_rsp_s cpu_rsp_o,
    output l2_cache_pkg::mem_req_s mem_req_o,
    input  l2_cache_pkg::mem_rsp_s mem_rsp_i
);

    logic                    hit;
    logic [`L2_WAY_W-1:0]    hit_way;
    logic [`L2_WAY_W-1:0]    victim_way;
    logic                    victim_dirty;
    logic [`L2_TAG_W-1:0]    victim_tag;
    logic                    tag_fill;
    logic                    tag_set_dirty;
    logic [`L2_WAY_W-1:0]    tag_way;

    logic                    data_we;
    logic [`L2_WAY_W-1:0]    data_way;
    logic [`L2_OFFSET_W-1:0] data_word;
    logic                    data_src_refill;
    logic [`L2_DATA_W-1:0]   rd_data;

    logic                    move_start;
    logic                    move_write;
    logic                    move_done;
    l2_cache_pkg::l2_addr_u  move_base;
    logic [`L2_OFFSET_W-1:0] mv_rd_word;
    logic                    refill_we;
    logic [`L2_OFFSET_W-1:0] refill_word;
    logic [`L2_DATA_W-1:0]   refill_data;

    logic                    st_we;
    logic [`L2_OFFSET_W-1:0] st_wr_word;
    logic [`L2_DATA_W-1:0]   st_wr_data;
    logic [`L2_OFFSET_W-1:0] st_rd_word;

    // data store port steering
    assign st_we      = data_src_refill ? refill_we : data_we;
    assign st_wr_word = data_src_refill ? refill_word : data_word;
    assign st_wr_data = data_src_refill ? refill_data : cpu_req_i.dat;
    assign st_rd_word = move_write ? mv_rd_word : cpu_req_i.adr.f.word;  // writeback reads ahead

    l2_ctrl_fsm u_ctrl (
        .clk               (clk),
        .rstn              (rstn),
        .cpu_req_i         (cpu_req_i),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .victim_way_i      (victim_way),
        .victim_dirty_i    (victim_dirty),
        .victim_tag_i      (victim_tag),
        .rd_data_i         (rd_data),
        .move_done_i       (move_done),
        .cpu_rsp_o         (cpu_rsp_o),
        .tag_fill_o        (tag_fill),
        .tag_set_dirty_o   (tag_set_dirty),
        .tag_way_o         (tag_way),
        .data_we_o         (data_we),
        .data_way_o        (data_way),
        .data_word_o       (data_word),
        .data_src_refill_o (data_src_refill),
        .move_start_o      (move_start),
        .move_write_o      (move_write),
        .move_base_o       (move_base)
    );

    l2_tag_store u_tags (
        .clk            (clk),
        .rstn           (rstn),
        .lookup_addr_i  (cpu_req_i.adr),
        .fill_i         (tag_fill),
        .set_dirty_i    (tag_set_dirty),
        .way_i          (tag_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    l2_data_store u_data (
        .clk        (clk),
        .rd_way_i   (data_way),
        .rd_index_i (cpu_req_i.adr.f.index),
        .rd_word_i  (st_rd_word),
        .we_i       (st_we),
        .wr_way_i   (data_way),
        .wr_index_i (cpu_req_i.adr.f.index),
        .wr_word_i  (st_wr_word),
        .wr_data_i  (st_wr_data),
        .rd_data_o  (rd_data)
    );

    l2_line_mover u_mover (
        .clk           (clk),
        .rstn          (rstn),
        .start_i       (move_start),
        .write_i       (move_write),
        .base_i        (move_base),
        .rd_data_i     (rd_data),
        .mem_rsp_i     (mem_rsp_i),
        .done_o        (move_done),
        .rd_word_o     (mv_rd_word),
        .refill_we_o   (refill_we),
        .refill_word_o (refill_word),
        .refill_data_o (refill_data),
        .mem_req_o     (mem_req_o)
    );

endmodule

// ==== design/l2_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rstn,
    input  l2_cache_pkg::cpu_req_s  cpu_req_i,
    input  logic                    hit_i,
    input  logic [`L2_WAY_W-1:0]    hit_way_i,
    input  logic [`L2_WAY_W-1:0]    victim_way_i,
    input  logic                    victim_dirty_i,
    input  logic [`L2_TAG_W-1:0]    victim_tag_i,
    input  logic [`L2_DATA_W-1:0]   rd_data_i,
    input  logic                    move_done_i,
    output l2_cache_pkg::cpu_rsp_s  cpu_rsp_o,
    output logic                    tag_fill_o,
    output logic                    tag_set_dirty_o,
    output logic [`L2_WAY_W-1:0]    tag_way_o,
    output logic                    data_we_o,
    output logic [`L2_WAY_W-1:0]    data_way_o,
    output logic [`L2_OFFSET_W-1:0] data_word_o,
    output logic                    data_src_refill_o,
    output logic                    move_start_o,
    output logic                    move_write_o,
    output l2_cache_pkg::l2_addr_u  move_base_o
);

    localparam logic [2:0] ST_IDLE          = 3'd0;
    localparam logic [2:0] ST_LOOKUP        = 3'd1;
    localparam logic [2:0] ST_WRITEBACK     = 3'd2;
    localparam logic [2:0] ST_REFILL        = 3'd3;
    localparam logic [2:0] ST_REPLACE_WRITE = 3'd4;
    localparam logic [2:0] ST_DONE          = 3'd5;

    logic [2:0]             state_q;
    logic [2:0]             state_d;
    logic                   req_valid;
    logic                   req_we_q;
    l2_cache_pkg::l2_addr_u req_adr_q;
    logic [`L2_WAY_W-1:0]   way_q;      // victim way kept across the miss
    logic                   way_we;
    l2_cache_pkg::l2_addr_u line_adr;
    l2_cache_pkg::l2_addr_u victim_adr;

    assign req_valid = cpu_req_i.cyc && cpu_req_i.stb;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_valid) begin
            req_we_q  <= cpu_req_i.we;
            req_adr_q <= cpu_req_i.adr;
        end
        if (way_we) begin
            way_q <= victim_way_i;
        end
    end

    // line base of the request and of the victim
    always_comb begin
        line_adr            = req_adr_q;
        line_adr.f.word     = '0;
        line_adr.f.byte_off = '0;
        victim_adr          = line_adr;
        victim_adr.f.tag    = victim_tag_i;
    end

    //////////////////////////////////////////////////////////////////////
    // next state and controls
    always_comb begin
        state_d           = state_q;
        cpu_rsp_o.ack     = 1'b0;
        cpu_rsp_o.dat     = rd_data_i;
        tag_fill_o        = 1'b0;
        tag_set_dirty_o   = 1'b0;
        tag_way_o         = way_q;
        data_we_o         = 1'b0;
        data_way_o        = way_q;
        data_word_o       = req_adr_q.f.word;
        data_src_refill_o = 1'b0;
        move_start_o      = 1'b0;
        move_write_o      = 1'b0;
        move_base_o       = line_adr;
        way_we            = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req_valid) begin
                    state_d = ST_LOOKUP;  // tags and data read this cycle
                end
            end
            ST_LOOKUP: begin
                if (hit_i) begin
                    cpu_rsp_o.ack = 1'b1;
                    tag_way_o     = hit_way_i;
                    data_way_o    = hit_way_i;
                    if (req_we_q) begin
                        data_we_o       = 1'b1;
                        tag_set_dirty_o = 1'b1;
                    end
                    state_d = ST_IDLE;
                end else begin
                    way_we       = 1'b1;
                    move_start_o = 1'b1;
                    if (victim_dirty_i) begin
                        move_write_o = 1'b1;
                        move_base_o  = victim_adr;
                        state_d      = ST_WRITEBACK;
                    end else begin
                        state_d = ST_REFILL;
                    end
                end
            end
            ST_WRITEBACK: begin
                if (move_done_i) begin
                    move_start_o = 1'b1;  // refill right behind the writeback
                    state_d      = ST_REFILL;
                end else begin
                    move_write_o = 1'b1;
                end
            end
            ST_REFILL: begin
                data_src_refill_o = 1'b1;
                if (move_done_i) begin
                    tag_fill_o = 1'b1;
                    state_d    = req_we_q ? ST_REPLACE_WRITE : ST_DONE;
                end
            end
            ST_REPLACE_WRITE: begin
                data_we_o       = 1'b1;
                tag_set_dirty_o = 1'b1;
                state_d         = ST_DONE;
            end
            ST_DONE: begin
                cpu_rsp_o.ack = 1'b1;  // read data fetched from the new line
                state_d       = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule

// ==== design/l2_data_store.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_data_store (
    input  logic                    clk,
    input  logic [`L2_WAY_W-1:0]    rd_way_i,
    input  logic [`L2_INDEX_W-1:0]  rd_index_i,
    input  logic [`L2_OFFSET_W-1:0] rd_word_i,
    input  logic                    we_i,
    input  logic [`L2_WAY_W-1:0]    wr_way_i,
    input  logic [`L2_INDEX_W-1:0]  wr_index_i,
    input  logic [`L2_OFFSET_W-1:0] wr_word_i,
    input  logic [`L2_DATA_W-1:0]   wr_data_i,
    output logic [`L2_DATA_W-1:0]   rd_data_o
);

    localparam int SETS  = 1 << `L2_INDEX_W;
    localparam int WORDS = 1 << `L2_OFFSET_W;

    logic [`L2_DATA_W-1:0] mem  [`L2_WAYS][SETS][WORDS];
    logic [`L2_DATA_W-1:0] rd_q [`L2_WAYS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_way_i][wr_index_i][wr_word_i] <= wr_data_i;
        end
        // all ways read in parallel, way picked late
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_q[w] <= mem[w][rd_index_i][rd_word_i];
        end
    end

    assign rd_data_o = rd_q[rd_way_i];  // hit way known only in lookup

endmodule

// ==== design/l2_line_mover.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_line_mover (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start_i,
    input  logic                    write_i,
    input  l2_cache_pkg::l2_addr_u  base_i,
    input  logic [`L2_DATA_W-1:0]   rd_data_i,
    input  l2_cache_pkg::mem_rsp_s  mem_rsp_i,
    output logic                    done_o,
    output logic [`L2_OFFSET_W-1:0] rd_word_o,
    output logic                    refill_we_o,
    output logic [`L2_OFFSET_W-1:0] refill_word_o,
    output logic [`L2_DATA_W-1:0]   refill_data_o,
    output l2_cache_pkg::mem_req_s  mem_req_o
);

    localparam logic [1:0] MV_IDLE = 2'd0;
    localparam logic [1:0] MV_GAP  = 2'd1;  // cyc held, stb low
    localparam logic [1:0] MV_BUS  = 2'd2;
    localparam logic [1:0] MV_DONE = 2'd3;

    logic [1:0]              state_q;
    logic [`L2_OFFSET_W-1:0] cnt_q;
    logic                    write_q;
    l2_cache_pkg::l2_addr_u  base_q;
    l2_cache_pkg::l2_addr_u  word_adr;
    logic                    bus_ack;

    assign bus_ack = (state_q == MV_BUS) && mem_rsp_i.ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= MV_IDLE;
            cnt_q   <= '0;
            write_q <= 1'b0;
        end else if (start_i) begin
            cnt_q   <= '0;
            write_q <= write_i;
            state_q <= write_i ? MV_GAP : MV_BUS;  // writeback prefetches word 0
        end else begin
            case (state_q)
                MV_GAP: begin
                    state_q <= MV_BUS;
                end
                MV_BUS: begin
                    if (mem_rsp_i.ack) begin
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= (cnt_q == '1) ? MV_DONE : MV_GAP;
                    end
                end
                MV_DONE: begin
                    state_q <= MV_IDLE;
                end
                default: begin
                    state_q <= MV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            base_q <= base_i;
        end
    end

    always_comb begin
        word_adr            = base_q;
        word_adr.f.word     = cnt_q;
        word_adr.f.byte_off = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // wishbone master and store side
    always_comb begin
        mem_req_o.cyc = (state_q == MV_GAP) || (state_q == MV_BUS);
        mem_req_o.stb = state_q == MV_BUS;
        mem_req_o.we  = write_q;
        mem_req_o.adr = word_adr.raw;
        mem_req_o.dat = rd_data_i;  // read one cycle ahead
    end

    assign rd_word_o     = cnt_q;
    assign refill_we_o   = bus_ack && !write_q;
    assign refill_word_o = cnt_q;
    assign refill_data_o = mem_rsp_i.dat;
    assign done_o        = state_q == MV_DONE;

endmodule

// ==== design/l2_tag_store.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_tag_store (
    input  logic                   clk,
    input  logic                   rstn,
    input  l2_cache_pkg::l2_addr_u lookup_addr_i,
    input  logic                   fill_i,
    input  logic                   set_dirty_i,
    input  logic [`L2_WAY_W-1:0]   way_i,
    output logic                   hit_o,
    output logic [`L2_WAY_W-1:0]   hit_way_o,
    output logic [`L2_WAY_W-1:0]   victim_way_o,
    output logic                   victim_dirty_o,
    output logic [`L2_TAG_W-1:0]   victim_tag_o
);

    localparam int SETS = 1 << `L2_INDEX_W;

    logic [`L2_TAG_W-1:0]   tag_mem [`L2_WAYS][SETS];
    logic [`L2_WAYS-1:0]    valid_q [SETS];
    logic [`L2_WAYS-1:0]    dirty_q [SETS];
    logic [`L2_WAY_W-1:0]   rr_q    [SETS];  // next victim per set

    logic [`L2_TAG_W-1:0]   tag_rd_q [`L2_WAYS];
    logic [`L2_WAYS-1:0]    valid_rd_q;
    logic [`L2_WAYS-1:0]    dirty_rd_q;
    logic [`L2_WAY_W-1:0]   rr_rd_q;
    logic [`L2_TAG_W-1:0]   cmp_tag_q;
    logic [`L2_WAYS-1:0]    hit_vec;
    logic [`L2_INDEX_W-1:0] idx;

    assign idx = lookup_addr_i.f.index;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_i) begin
            valid_q[idx][way_i] <= 1'b1;
            dirty_q[idx][way_i] <= 1'b0;  // fresh line from memory
            rr_q[idx]           <= rr_q[idx] + 1'b1;
        end else if (set_dirty_i) begin
            dirty_q[idx][way_i] <= 1'b1;
        end
    end

    // tag write and registered read of the whole set
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[way_i][idx] <= lookup_addr_i.f.tag;
        end
        for (int w = 0; w < `L2_WAYS; w++) begin
            tag_rd_q[w] <= tag_mem[w][idx];
        end
        valid_rd_q <= valid_q[idx];
        dirty_rd_q <= dirty_q[idx];
        rr_rd_q    <= rr_q[idx];
        cmp_tag_q  <= lookup_addr_i.f.tag;
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_vec[w] = valid_rd_q[w] && (tag_rd_q[w] == cmp_tag_q);
        end
    end

    // lowest way wins
    always_comb begin
        hit_way_o = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way_o = w[`L2_WAY_W-1:0];
            end
        end
    end

    assign hit_o          = |hit_vec;
    assign victim_way_o   = rr_rd_q;
    assign victim_dirty_o = valid_rd_q[rr_rd_q] && dirty_rd_q[rr_rd_q];
    assign victim_tag_o   = tag_rd_q[rr_rd_q];

endmodule

// ==== l2_cache.f ====
+incdir+design
design/l2_cache_pkg.sv
design/l2_data_store.sv
design/l2_tag_store.sv
design/l2_line_mover.sv
design/l2_ctrl_fsm.sv
design/l2_cache_top.sv
tb/l2_cache_checker.sv
tb/l2_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module l2_cache_tb \
    -f l2_cache.f -o l2_cache_sim

./obj_dir/l2_cache_sim > sim.log
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/l2_cache_checker.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_checker (
    input  logic                   clk,
    input  logic                   rstn,
    input  l2_cache_pkg::cpu_req_s cpu_req_i,
    input  l2_cache_pkg::cpu_rsp_s cpu_rsp_i,
    input  l2_cache_pkg::mem_req_s mem_req_i,
    output int                     data_errors_o,
    output int                     protocol_errors_o,
    output int                     reads_checked_o,
    output int                     acks_seen_o
);

    logic [`L2_DATA_W-1:0] shadow [logic [`L2_ADDR_W-1:0]];  // words written so far
    logic                  seen_req = 1'b0;
    int                    data_errors = 0;
    int                    protocol_errors = 0;
    int                    reads_checked = 0;
    int                    acks_seen = 0;

    assign data_errors_o     = data_errors;
    assign protocol_errors_o = protocol_errors;
    assign reads_checked_o   = reads_checked;
    assign acks_seen_o       = acks_seen;

    // same start pattern as the memory model
    function automatic logic [`L2_DATA_W-1:0] fill_word(input logic [`L2_ADDR_W-1:0] adr);
        return {adr[15:0], adr[31:16]} ^ adr ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [`L2_DATA_W-1:0] expected_read(input logic [`L2_ADDR_W-1:0] adr);
        if (shadow.exists(adr)) begin
            return shadow[adr];
        end
        return fill_word(adr);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare mid-cycle, ack is combinational
    always @(negedge clk) begin
        logic [`L2_DATA_W-1:0] exp_dat;
        if (!seen_req && (cpu_rsp_i.ack !== 1'b0 || mem_req_i.cyc !== 1'b0)) begin
            protocol_errors++;
            $display("error %0t: ack or memory cycle active before the first request", $time);
        end
        if (rstn && cpu_req_i.cyc && cpu_req_i.stb) begin
            seen_req = 1'b1;
        end
        if (cpu_rsp_i.ack === 1'b1) begin
            acks_seen++;
            if (!(cpu_req_i.cyc && cpu_req_i.stb)) begin
                protocol_errors++;
                $display("error %0t: ack without an active strobe", $time);
            end else if (cpu_req_i.we) begin
                shadow[cpu_req_i.adr.raw] = cpu_req_i.dat;
            end else begin
                exp_dat = expected_read(cpu_req_i.adr.raw);
                reads_checked++;
                if (cpu_rsp_i.dat !== exp_dat) begin
                    data_errors++;
                    $display("error %0t: read at %08h returned %08h, expected %08h",
                             $time, cpu_req_i.adr.raw, cpu_rsp_i.dat, exp_dat);
                end
            end
        end
    end

endmodule

// ==== tb/l2_cache_tb.sv ====
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_XFERS   = 300;
    localparam int NUM_XFERS    = 13 + RAND_XFERS;  // directed plus random
    localparam int TIMEOUT_NS   = (NUM_XFERS * 200 + RESET_CYCLES) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   rstn;
    l2_cache_pkg::cpu_req_s cpu_req;
    l2_cache_pkg::cpu_rsp_s cpu_rsp;
    l2_cache_pkg::mem_req_s mem_req;
    l2_cache_pkg::mem_rsp_s mem_rsp;

    logic [`L2_DATA_W-1:0] mem_words [logic [`L2_ADDR_W-1:0]];
    logic [31:0]           stim_lfsr  = 32'h73e5;
    logic [31:0]           mem_lfsr   = 32'h73e5;
    logic                  wait_armed = 1'b0;
    logic [1:0]            wait_left  = '0;
    int                    issued = 0;
    int                    failures;
    int                    data_errors;
    int                    protocol_errors;
    int                    reads_checked;
    int                    acks_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    l2_cache_top u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    l2_cache_checker u_checker (
        .clk               (clk),
        .rstn              (rstn),
        .cpu_req_i         (cpu_req),
        .cpu_rsp_i         (cpu_rsp),
        .mem_req_i         (mem_req),
        .data_errors_o     (data_errors),
        .protocol_errors_o (protocol_errors),
        .reads_checked_o   (reads_checked),
        .acks_seen_o       (acks_seen)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits  = {bits[30:0], state[31]};
            state = lfsr_next(state);
        end
    endtask

    function automatic logic [`L2_DATA_W-1:0] fill_word(input logic [`L2_ADDR_W-1:0] adr);
        return {adr[15:0], adr[31:16]} ^ adr ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [23:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 24'h000a01;
            2'd1:    return 24'h0000b2;
            2'd2:    return 24'h01c0d3;
            default: return 24'h7e0004;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // backing memory with 0 to 3 wait states per word
    always @(posedge clk) begin
        logic [31:0] bits;
        #1;
        mem_rsp.ack = 1'b0;
        if (rstn && mem_req.cyc === 1'b1 && mem_req.stb === 1'b1) begin
            if (!wait_armed) begin
                take_bits(mem_lfsr, 2, bits);
                wait_left  = bits[1:0];
                wait_armed = 1'b1;
            end
            if (wait_left == 2'd0) begin
                mem_rsp.ack = 1'b1;
                wait_armed  = 1'b0;
                if (mem_req.we) begin
                    mem_words[mem_req.adr] = mem_req.dat;
                end else if (mem_words.exists(mem_req.adr)) begin
                    mem_rsp.dat = mem_words[mem_req.adr];
                end else begin
                    mem_rsp.dat = fill_word(mem_req.adr);
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // requester transfers start 1 ns after a rising edge
    task automatic cpu_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat);
        cpu_req.cyc     = 1'b1;
        cpu_req.stb     = 1'b1;
        cpu_req.we      = we;
        cpu_req.adr.raw = adr;
        cpu_req.dat     = dat;
        issued++;
        do begin
            @(negedge clk);
        end while (cpu_rsp.ack !== 1'b1);
        @(posedge clk);
        #1;
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        cpu_req.we  = 1'b0;
        @(posedge clk);  // idle cycle before the next request
        #1;
    endtask

    task automatic random_mix();
        logic [31:0] bits;
        logic [31:0] dat;
        logic        we;
        logic [23:0] tag;
        logic [3:0]  idx;
        logic [1:0]  word;
        for (int i = 0; i < RAND_XFERS; i++) begin
            take_bits(stim_lfsr, 1, bits);
            we = bits[0];
            take_bits(stim_lfsr, 2, bits);
            tag = pick_tag(bits[1:0]);
            take_bits(stim_lfsr, 1, bits);
            idx = bits[0] ? 4'hc : 4'h5;
            take_bits(stim_lfsr, 2, bits);
            word = bits[1:0];
            take_bits(stim_lfsr, 32, dat);
            cpu_transfer(we, {tag, idx, word, 2'b00}, dat);
        end
    endtask

    initial begin
        rstn    = 1'b0;
        cpu_req = '0;
        mem_rsp = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (4) @(posedge clk);  // quiet bus watched by the checker
        #1;

        // read miss then hits on the same line
        cpu_transfer(1'b0, 32'h0000_1040, '0);
        cpu_transfer(1'b0, 32'h0000_1040, '0);
        cpu_transfer(1'b0, 32'h0000_104c, '0);

        // write miss and write hit with a read back of each
        cpu_transfer(1'b1, 32'h0000_2088, 32'hcafe_0001);
        cpu_transfer(1'b0, 32'h0000_2088, '0);
        cpu_transfer(1'b1, 32'h0000_2088, 32'hcafe_0002);
        cpu_transfer(1'b0, 32'h0000_2088, '0);

        // three tags on set 7 force dirty evictions
        cpu_transfer(1'b1, 32'h0000_3174, 32'h1111_aaaa);
        cpu_transfer(1'b1, 32'h0000_3274, 32'h2222_bbbb);
        cpu_transfer(1'b1, 32'h0000_3374, 32'h3333_cccc);
        cpu_transfer(1'b0, 32'h0000_3174, '0);
        cpu_transfer(1'b0, 32'h0000_3274, '0);
        cpu_transfer(1'b0, 32'h0000_3374, '0);

        random_mix();

        repeat (4) @(posedge clk);
        failures = data_errors + protocol_errors;
        if (acks_seen != issued) begin
            $display("transfer count wrong: %0d issued, %0d acked", issued, acks_seen);
            failures++;
        end
        $display("data errors %0d, protocol errors %0d, other failures %0d, reads checked %0d",
                 data_errors, protocol_errors, failures - data_errors - protocol_errors,
                 reads_checked);
        if (failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
